/* rvseed_div.f */
rvseed_div_pkg.sv
div_operand_prep.sv
divider_cell.sv
divider_array.sv
div_ctrl_pipe.sv
div_result_fix.sv
rvseed_div.sv
tb_rvseed_div.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the testbench with Verilator and runs it; exit status follows the run

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f rvseed_div.f \
    --top-module tb_rvseed_div \
    -o sim_rvseed_div \
    && ./obj_dir/sim_rvseed_div \
    || { echo "build or simulation returned an error"; exit 1; }

/* tb_rvseed_div.sv */
module tb_rvseed_div
    import rvseed_div_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int XLEN      = 32;
    localparam int LATENCY   = XLEN + 1; // drive cycle to result cycle
    localparam int DRIVE_DLY = 10;
    localparam int DRAIN_MAX = 4 * XLEN;

    typedef struct packed {
        logic [XLEN-1:0] value;
        logic [31:0]     issue_cycle;
        div_op_t         op;
    } pending_t;

    logic            clk;
    logic            rstn;
    logic            in_valid;
    logic [XLEN-1:0] dividend;
    logic [XLEN-1:0] divisor;
    div_op_t         op;
    logic            res_valid;
    logic [XLEN-1:0] result;

    pending_t        pending_q [$];
    logic [31:0]     cycle_cnt = '0;
    int              seed      = 32'h8d9b;

    rvseed_div #(
        .XLEN (XLEN)
    ) i_dut (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .dividend  (dividend),
        .divisor   (divisor),
        .op        (op),
        .res_valid (res_valid),
        .result    (result)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    // RISC-V M-extension divide semantics
    function automatic logic [XLEN-1:0] rv_div_ref(input div_op_t f_op,
                                                   input logic [XLEN-1:0] a,
                                                   input logic [XLEN-1:0] b);
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic [XLEN-1:0]        min_val;
        sa      = a;
        sb      = b;
        min_val = {1'b1, {(XLEN-1){1'b0}}};
        if (b == '0) begin
            return f_op[1] ? a : '1;
        end
        if (f_op == op_div || f_op == op_rem) begin
            if (a == min_val && b == '1) begin
                return (f_op == op_rem) ? '0 : a;
            end
            return (f_op == op_rem) ? sa % sb : sa / sb;
        end
        return (f_op == op_remu) ? a % b : a / b;
    endfunction

    task automatic issue_op(input div_op_t f_op, input logic [XLEN-1:0] a,
                            input logic [XLEN-1:0] b);
        pending_t entry;
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b1;
        dividend = a;
        divisor  = b;
        op       = f_op;
        entry.value       = rv_div_ref(f_op, a, b);
        entry.issue_cycle = cycle_cnt;
        entry.op          = f_op;
        pending_q.push_back(entry);
    endtask

    task automatic go_idle();
        @(posedge clk);
        #DRIVE_DLY;
        in_valid = 1'b0;
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (pending_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > DRAIN_MAX) begin
                stop_run($sformatf("timed out waiting for %0d outstanding results",
                                   pending_q.size()));
            end
        end
    endtask

    // one pop per result pulse, sampled mid-cycle
    always @(negedge clk) begin
        pending_t exp_entry;
        if (rstn && res_valid) begin
            assert (pending_q.size() != 0)
                else stop_run("result pulse seen with no operation outstanding");
            exp_entry = pending_q.pop_front();
            assert (result === exp_entry.value)
                else stop_run($sformatf("MISMATCH result expected=%h actual=%h op=%h",
                                        exp_entry.value, result, exp_entry.op));
            assert (cycle_cnt - exp_entry.issue_cycle == LATENCY)
                else stop_run($sformatf("result came %0d cycles after issue, not %0d",
                                        cycle_cnt - exp_entry.issue_cycle, LATENCY));
        end
    end

    initial begin
        #1_000_000;
        stop_run("simulation ran past its time limit");
    end

    initial begin
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] min_val;
        div_op_t         rop;
        int              gap;
        min_val  = {1'b1, {(XLEN-1){1'b0}}};
        rstn     = 1'b0;
        in_valid = 1'b0;
        dividend = '0;
        divisor  = '0;
        op       = op_divu;
        repeat (5) @(posedge clk);
        #DRIVE_DLY;
        rstn = 1'b1;

        repeat (8) begin // quiet output before first op
            @(negedge clk);
            assert (res_valid === 1'b0)
                else stop_run("res_valid went high before any operation was issued");
        end

        for (int k = 0; k < 2; k++) begin
            rop = k ? op_remu : op_divu;
            issue_op(rop, 32'hdead_beef, 32'h1);
            issue_op(rop, 32'h5, 32'h7);
            issue_op(rop, '1, '1);
            issue_op(rop, '1, 32'h1);
            issue_op(rop, '1, 32'h3);
            issue_op(rop, 32'h7, '1);
            issue_op(rop, 32'h1234_5678, 32'h10);
            for (int i = 0; i < 20; i++) begin
                a = $random(seed);
                b = $random(seed) >> (i % 8 * 4); // spread quotient sizes
                issue_op(rop, a, (b == '0) ? 32'h1 : b);
            end
        end
        go_idle();
        wait_drain();

        for (int s = 0; s < 4; s++) begin
            for (int i = 0; i < 8; i++) begin
                a = $random(seed) & 32'h7fff_ffff;
                b = ($random(seed) >> (i * 4)) & 32'h7fff_ffff;
                if (b == '0) begin
                    b = 32'h1;
                end
                a = s[0] ? ~a + 1'b1 : a;
                b = s[1] ? ~b + 1'b1 : b;
                issue_op(op_div, a, b);
                issue_op(op_rem, a, b);
            end
            issue_op(op_div, s[0] ? -32'sd7 : 32'sd7, s[1] ? -32'sd2 : 32'sd2);
            issue_op(op_rem, s[0] ? -32'sd7 : 32'sd7, s[1] ? -32'sd2 : 32'sd2);
        end
        go_idle();
        wait_drain();

        for (int k = 0; k < 4; k++) begin
            rop = div_op_t'(k);
            issue_op(rop, $random(seed), '0);
            issue_op(rop, '0, '0);
            issue_op(rop, min_val, '0);
            issue_op(rop, min_val, '1); // signed overflow case
        end
        go_idle();
        wait_drain();

        for (int i = 0; i < 40; i++) begin
            rop = div_op_t'($random(seed) & 3);
            issue_op(rop, $random(seed), $random(seed) >> (i % 4 * 8));
        end
        for (int i = 0; i < 40; i++) begin
            rop = div_op_t'($random(seed) & 3);
            issue_op(rop, $random(seed), $random(seed) >> (i % 4 * 8));
            gap = $random(seed) & 3;
            repeat (gap) go_idle();
        end
        go_idle();
        wait_drain();

        repeat (4) @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule

/* rvseed_div.sv */
module rvseed_div
    import rvseed_div_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            in_valid,
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    input  div_op_t         op,
    output logic            res_valid,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] dividend_mag;
    logic [XLEN-1:0] divisor_mag;
    div_ctrl_t       prep_ctrl;
    logic            arr_rdy;
    logic [XLEN-1:0] quot_mag;
    logic [XLEN-1:0] rem_mag;
    logic [XLEN-1:0] dividend_kp;
    logic            pipe_valid;
    div_ctrl_t       pipe_ctrl;

    div_operand_prep #(
        .XLEN (XLEN)
    ) i_prep (
        .dividend     (dividend),
        .divisor      (divisor),
        .op           (op),
        .dividend_mag (dividend_mag),
        .divisor_mag  (divisor_mag),
        .ctrl         (prep_ctrl)
    );

    divider_array #(
        .XLEN (XLEN)
    ) i_array (
        .clk          (clk),
        .rstn         (rstn),
        .en           (in_valid),
        .dividend_mag ({XLEN{in_valid}} & dividend_mag), // idle cycles feed zeros
        .divisor_mag  ({XLEN{in_valid}} & divisor_mag),
        .rdy          (arr_rdy),
        .quot_mag     (quot_mag),
        .rem_mag      (rem_mag),
        .dividend_kp  (dividend_kp)
    );

    div_ctrl_pipe #(
        .DEPTH (XLEN)
    ) i_ctrl_pipe (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .in_ctrl   (prep_ctrl),
        .out_valid (pipe_valid),
        .out_ctrl  (pipe_ctrl)
    );

    div_result_fix #(
        .XLEN (XLEN)
    ) i_result_fix (
        .clk           (clk),
        .rstn          (rstn),
        .in_valid      (pipe_valid),
        .arr_rdy       (arr_rdy),
        .ctrl          (pipe_ctrl),
        .quot_mag      (quot_mag),
        .rem_mag       (rem_mag),
        .dividend_orig (dividend_kp),
        .res_valid     (res_valid),
        .result        (result)
    );

endmodule

/* div_result_fix.sv */
module div_result_fix
    import rvseed_div_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            in_valid,
    input  logic            arr_rdy,
    input  div_ctrl_t       ctrl,
    input  logic [XLEN-1:0] quot_mag,
    input  logic [XLEN-1:0] rem_mag,
    input  logic [XLEN-1:0] dividend_orig,
    output logic            res_valid,
    output logic [XLEN-1:0] result
);

    logic [XLEN-1:0] quot_signed;
    logic [XLEN-1:0] rem_signed;
    logic [XLEN-1:0] dividend_full;
    logic [XLEN-1:0] quot_fix;
    logic [XLEN-1:0] rem_fix;
    logic [XLEN-1:0] result_d;

    assign quot_signed = ctrl.neg_quot ? ~quot_mag + 1'b1 : quot_mag;
    assign rem_signed  = ctrl.neg_rem ? ~rem_mag + 1'b1 : rem_mag;

    // dividend_orig is the kept magnitude; when its msb differs from the
    // raw sign bit it was negated in prep and gets negated back
    assign dividend_full = (ctrl.dividend_sign ^ dividend_orig[XLEN-1]) ?
                           ~dividend_orig + 1'b1 : dividend_orig;

    always_comb begin
        if (ctrl.div_zero) begin
            quot_fix = '1;
            rem_fix  = dividend_full;
        end else if (ctrl.overflow) begin
            quot_fix = dividend_full; // min value back out
            rem_fix  = '0;
        end else begin
            quot_fix = quot_signed;
            rem_fix  = rem_signed;
        end
        result_d = ctrl.want_rem ? rem_fix : quot_fix;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            res_valid <= 1'b0;
        end else begin
            res_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            result <= result_d;
        end
    end

    // control pipe and data array must stay in lockstep
    a_valid_sources_agree: assert property (
        @(posedge clk) disable iff (!rstn)
        in_valid == arr_rdy
    ) else $error("control pipe valid and array rdy disagree");

endmodule

/* div_ctrl_pipe.sv */
module div_ctrl_pipe
    import rvseed_div_pkg::*;
#(
    parameter int DEPTH = 32
) (
    input  logic      clk,
    input  logic      rstn,
    input  logic      in_valid,
    input  div_ctrl_t in_ctrl,
    output logic      out_valid,
    output div_ctrl_t out_ctrl
);

    logic [DEPTH-1:0] valid_q;
    div_ctrl_t        ctrl_q [DEPTH];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[DEPTH-2:0], in_valid};
        end
    end

    // flags move only together with a live op
    always_ff @(posedge clk) begin
        if (in_valid) begin
            ctrl_q[0] <= in_ctrl;
        end
        for (int s = 1; s < DEPTH; s++) begin
            if (valid_q[s-1]) begin
                ctrl_q[s] <= ctrl_q[s-1];
            end
        end
    end

    assign out_valid = valid_q[DEPTH-1];
    assign out_ctrl  = ctrl_q[DEPTH-1];

endmodule

/* divider_array.sv */
module divider_array #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            en,
    input  logic [XLEN-1:0] dividend_mag,
    input  logic [XLEN-1:0] divisor_mag,
    output logic            rdy,
    output logic [XLEN-1:0] quot_mag,
    output logic [XLEN-1:0] rem_mag,
    output logic [XLEN-1:0] dividend_kp
);

    // index 0 is the seed, index i+1 is the output of cell i
    logic            rdy_c      [XLEN+1];
    logic [XLEN-1:0] rem_c      [XLEN+1];
    logic [XLEN-1:0] quot_c     [XLEN+1];
    logic [XLEN-1:0] divisor_c  [XLEN+1];
    logic [XLEN-1:0] dividend_c [XLEN+1];

    assign rdy_c[0]      = en;
    assign rem_c[0]      = '0;
    assign quot_c[0]     = '0;
    assign divisor_c[0]  = divisor_mag;
    assign dividend_c[0] = dividend_mag;

    for (genvar i = 0; i < XLEN; i++) begin : g_step
        logic [XLEN:0] part_rem;

        // bring down the next dividend bit, msb first
        assign part_rem = {rem_c[i], dividend_c[i][XLEN-1-i]};

        divider_cell #(
            .XLEN (XLEN)
        ) i_cell (
            .clk           (clk),
            .rstn          (rstn),
            .en            (rdy_c[i]),
            .part_rem      (part_rem),
            .divisor       (divisor_c[i]),
            .quot_in       (quot_c[i]),
            .dividend_rest (dividend_c[i]),
            .rdy           (rdy_c[i+1]),
            .rem_out       (rem_c[i+1]),
            .quot_out      (quot_c[i+1]),
            .divisor_kp    (divisor_c[i+1]),
            .dividend_kp   (dividend_c[i+1])
        );
    end

    assign rdy         = rdy_c[XLEN];
    assign quot_mag    = quot_c[XLEN];
    assign rem_mag     = rem_c[XLEN];
    assign dividend_kp = dividend_c[XLEN]; // dividend magnitude, untouched

    a_rem_below_divisor: assert property (
        @(posedge clk) disable iff (!rstn)
        rdy && divisor_c[XLEN] != '0 |-> rem_mag < divisor_c[XLEN]
    ) else $error("array remainder is not below the divisor");

endmodule

/* divider_cell.sv */
module divider_cell #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rstn,
    input  logic            en,
    input  logic [XLEN:0]   part_rem,
    input  logic [XLEN-1:0] divisor,
    input  logic [XLEN-1:0] quot_in,
    input  logic [XLEN-1:0] dividend_rest,
    output logic            rdy,
    output logic [XLEN-1:0] rem_out,
    output logic [XLEN-1:0] quot_out,
    output logic [XLEN-1:0] divisor_kp,
    output logic [XLEN-1:0] dividend_kp
);

    logic            fits;
    logic [XLEN-1:0] diff;

    // partial remainder is below twice the divisor
    assign fits = part_rem >= {1'b0, divisor};

    // low bits are exact whenever fits is set
    assign diff = part_rem[XLEN-1:0] - divisor;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rdy <= 1'b0;
        end else begin
            rdy <= en;
        end
    end

    always_ff @(posedge clk) begin
        if (fits) begin
            rem_out  <= diff;
            quot_out <= {quot_in[XLEN-2:0], 1'b1};
        end else begin
            rem_out  <= part_rem[XLEN-1:0]; // restore
            quot_out <= {quot_in[XLEN-2:0], 1'b0};
        end
        divisor_kp  <= divisor;
        dividend_kp <= dividend_rest;
    end

endmodule

/* div_operand_prep.sv */
module div_operand_prep
    import rvseed_div_pkg::*;
#(
    parameter int XLEN = 32
) (
    input  logic [XLEN-1:0] dividend,
    input  logic [XLEN-1:0] divisor,
    input  div_op_t         op,
    output logic [XLEN-1:0] dividend_mag,
    output logic [XLEN-1:0] divisor_mag,
    output div_ctrl_t       ctrl
);

    logic signed_op;
    logic dividend_neg;
    logic divisor_neg;
    logic min_dividend;
    logic minus_one;

    assign signed_op    = op[0];
    assign dividend_neg = signed_op & dividend[XLEN-1];
    assign divisor_neg  = signed_op & divisor[XLEN-1];

    assign min_dividend = dividend == {1'b1, {(XLEN-1){1'b0}}};
    assign minus_one    = &divisor;

    // two's complement magnitudes, min value maps onto itself
    assign dividend_mag = dividend_neg ? ~dividend + 1'b1 : dividend;
    assign divisor_mag  = divisor_neg ? ~divisor + 1'b1 : divisor;

    always_comb begin
        ctrl               = '0;
        ctrl.want_rem      = op[1];
        ctrl.neg_quot      = dividend_neg ^ divisor_neg;
        ctrl.neg_rem       = dividend_neg; // remainder follows dividend sign
        ctrl.div_zero      = divisor == '0;
        ctrl.overflow      = signed_op & min_dividend & minus_one;
        ctrl.dividend_sign = dividend[XLEN-1];
        ctrl.spare         = 1'b0;
    end

endmodule

/* rvseed_div_pkg.sv */
package rvseed_div_pkg;

    // bit 0 selects a signed op, bit 1 selects the remainder
    typedef logic [1:0] div_op_t;

    localparam div_op_t op_divu = 2'b00;
    localparam div_op_t op_div  = 2'b01;
    localparam div_op_t op_remu = 2'b10;
    localparam div_op_t op_rem  = 2'b11;

    // per-op flags that travel beside the array data
    typedef struct packed {
        logic want_rem;      // pick remainder instead of quotient
        logic neg_quot;      // operand signs differ
        logic neg_rem;       // signed op with negative dividend
        logic div_zero;      // divisor was zero
        logic overflow;      // most negative value / -1
        logic dividend_sign; // raw msb of the dividend
        logic spare;         // reserved, kept at zero
    } div_ctrl_t;

endpackage
